//--- hw/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ==============================
// lsu widths
// ==============================
`define LSU_XLEN 32  // data and address width
`define LSU_TAG_W 4  // issuer tag width

// ==============================
// rv32 major opcodes
// ==============================
`define LSU_OP_LOAD 7'b0000011
`define LSU_OP_STORE 7'b0100011

`endif

//--- hw/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    // ==============================
    // instruction word, two decodings
    // ==============================
    typedef struct packed {
        logic [11:0] imm;     // full 12-bit offset
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } ls_i_view_t;

    typedef struct packed {
        logic [6:0] imm_hi;   // offset bits 11:5
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;   // offset bits 4:0
        logic [6:0] opcode;
    } ls_s_view_t;

    typedef union packed {
        ls_i_view_t i_view;   // loads
        ls_s_view_t s_view;   // stores
    } lsu_instr_u;

    // funct3[1:0]
    typedef enum logic [1:0] {
        LS_BYTE = 2'b00,
        LS_HALF = 2'b01,
        LS_WORD = 2'b10
    } ls_width_t;

    // ==============================
    // request and load side info
    // ==============================
    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;     // byte address, low bits kept for align
        logic [3:0] be;
        logic [`LSU_XLEN-1:0] data_in;  // lane replicated store data
        logic load;
        logic store;
        ls_width_t width;
        logic is_unsigned;
        logic [`LSU_TAG_W-1:0] tag;
    } ls_request_t;

    typedef struct packed {
        logic [1:0] offset;   // byte lane of the load
        ls_width_t width;
        logic is_unsigned;
        logic [`LSU_TAG_W-1:0] tag;
    } ls_load_info_t;

endpackage

//--- hw/lsu_ifs.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

// ==============================
// avalon-mm, single transfers
// ==============================
interface avalon_if ();
    logic [`LSU_XLEN-1:0] addr;       // word aligned
    logic [3:0] byteenable;
    logic [`LSU_XLEN-1:0] writedata;
    logic read;
    logic write;
    logic [`LSU_XLEN-1:0] readdata;   // valid in completing read cycle
    logic waitrequest;                // stall, transfer done when low

    modport master (
        output addr, byteenable, writedata, read, write,
        input readdata, waitrequest
    );

    modport slave (
        input addr, byteenable, writedata, read, write,
        output readdata, waitrequest
    );
endinterface

// ==============================
// decode to bus sub-unit
// ==============================
interface ls_sub_unit_if import lsu_pkg::*; ();
    ls_request_t request;   // stable while new_request is high
    logic new_request;      // one cycle strobe, only when ready
    logic ready;            // level, sub-unit idle
    logic data_valid;       // one cycle pulse on read completion

    // bus side
    modport sub_unit (
        input request, new_request,
        output ready, data_valid
    );

    // decode side
    modport issuer (
        output request, new_request,
        input ready, data_valid
    );
endinterface

//--- hw/ls_decode.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module ls_decode import lsu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    output logic issue_ready,
    input lsu_instr_u instr,
    input logic [`LSU_XLEN-1:0] rs1_value,
    input logic [`LSU_XLEN-1:0] rs2_value,
    input logic [`LSU_TAG_W-1:0] issue_tag,
    ls_sub_unit_if.issuer ls
);

    logic is_load;
    logic is_store;
    logic [`LSU_XLEN-1:0] imm;       // sign extended offset
    ls_request_t next_req;
    ls_request_t held;               // single request holder
    logic held_valid;
    logic accept;

    // ==============================
    // decode
    // ==============================
    assign is_load = (instr.i_view.opcode == `LSU_OP_LOAD);
    assign is_store = (instr.s_view.opcode == `LSU_OP_STORE);

    always_comb begin
        // split offset for stores, contiguous for loads
        if (is_store)
            imm = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
        else
            imm = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};

        next_req.addr = rs1_value + imm;
        next_req.load = is_load;
        next_req.store = is_store;
        next_req.width = ls_width_t'(instr.i_view.funct3[1:0]);
        next_req.is_unsigned = instr.i_view.funct3[2];  // LBU/LHU
        next_req.tag = issue_tag;

        // lanes from width and low address bits
        case (next_req.width)
            LS_BYTE: begin
                next_req.be = 4'b0001 << next_req.addr[1:0];
                next_req.data_in = {4{rs2_value[7:0]}};
            end
            LS_HALF: begin
                next_req.be = next_req.addr[1] ? 4'b1100 : 4'b0011;
                next_req.data_in = {2{rs2_value[15:0]}};
            end
            default: begin
                next_req.be = 4'b1111;    // word
                next_req.data_in = rs2_value;
            end
        endcase
    end

    // ==============================
    // request holder
    // ==============================
    assign ls.new_request = held_valid & ls.ready;    // drains when bus idle
    assign issue_ready = ~held_valid | ls.ready;       // empty or draining now
    assign accept = issue_valid & issue_ready;
    assign ls.request = held;

    always_ff @(posedge clk) begin
        if (rst)
            held_valid <= 1'b0;
        else if (accept)
            held_valid <= 1'b1;   // refill wins over drain
        else if (ls.new_request)
            held_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept)
            held <= next_req;
    end

endmodule

//--- hw/avalon_master.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module avalon_master import lsu_pkg::*; (
    input logic clk,
    input logic rst,
    avalon_if.master m_avalon,
    output logic [31:0] data_out,
    ls_sub_unit_if.sub_unit ls,
    output ls_load_info_t load_info
);

    logic xfer_done;    // completing cycle of either transfer
    logic read_done;

    assign xfer_done = (m_avalon.read | m_avalon.write) & ~m_avalon.waitrequest;
    assign read_done = m_avalon.read & ~m_avalon.waitrequest;

    // ==============================
    // request capture
    // ==============================
    always_ff @(posedge clk) begin
        if (ls.new_request) begin
            m_avalon.addr <= {ls.request.addr[`LSU_XLEN-1:2], 2'b00};  // drop low bits
            m_avalon.byteenable <= ls.request.be;
            m_avalon.writedata <= ls.request.data_in;
            // travels to the align stage
            load_info.offset <= ls.request.addr[1:0];
            load_info.width <= ls.request.width;
            load_info.is_unsigned <= ls.request.is_unsigned;
            load_info.tag <= ls.request.tag;
        end
    end

    // ==============================
    // control
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            ls.ready <= 1'b1;
            m_avalon.read <= 1'b0;
            m_avalon.write <= 1'b0;
            ls.data_valid <= 1'b0;
        end else begin
            if (ls.new_request)
                ls.ready <= 1'b0;
            else if (xfer_done)
                ls.ready <= 1'b1;   // idle again after completion

            if (ls.new_request)
                m_avalon.read <= ls.request.load;
            else if (~m_avalon.waitrequest)
                m_avalon.read <= 1'b0;

            if (ls.new_request)
                m_avalon.write <= ls.request.store;
            else if (~m_avalon.waitrequest)
                m_avalon.write <= 1'b0;

            ls.data_valid <= read_done;  // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (read_done)
            data_out <= m_avalon.readdata;
    end

endmodule

//--- hw/ls_load_align.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module ls_load_align import lsu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic data_valid,
    input logic [31:0] data_in,
    input ls_load_info_t info,
    output logic load_valid,
    output logic [`LSU_TAG_W-1:0] load_tag,
    output logic [31:0] load_data
);

    logic [31:0] shifted;   // addressed lane moved to bit 0
    logic [31:0] result;
    logic sign_b;
    logic sign_h;

    // ==============================
    // select and extend
    // ==============================
    assign shifted = data_in >> {info.offset, 3'b000};
    assign sign_b = shifted[7] & ~info.is_unsigned;
    assign sign_h = shifted[15] & ~info.is_unsigned;

    always_comb begin
        case (info.width)
            LS_BYTE: result = {{24{sign_b}}, shifted[7:0]};
            LS_HALF: result = {{16{sign_h}}, shifted[15:0]};
            default: result = shifted;    // word, offset is 0
        endcase
    end

    // ==============================
    // result register
    // ==============================
    always_ff @(posedge clk) begin
        if (rst)
            load_valid <= 1'b0;
        else
            load_valid <= data_valid;   // no back-pressure on results
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            load_tag <= info.tag;
            load_data <= result;
        end
    end

endmodule

//--- hw/lsu_avalon_top.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module lsu_avalon_top import lsu_pkg::*; (
    input logic clk,
    input logic rst,
    // issue side
    input logic issue_valid,
    output logic issue_ready,
    input logic [31:0] instr,
    input logic [`LSU_XLEN-1:0] rs1_value,
    input logic [`LSU_XLEN-1:0] rs2_value,
    input logic [`LSU_TAG_W-1:0] issue_tag,
    // avalon master
    output logic [`LSU_XLEN-1:0] avm_addr,
    output logic [3:0] avm_byteenable,
    output logic [`LSU_XLEN-1:0] avm_writedata,
    output logic avm_read,
    output logic avm_write,
    input logic [`LSU_XLEN-1:0] avm_readdata,
    input logic avm_waitrequest,
    // load results
    output logic load_valid,
    output logic [`LSU_TAG_W-1:0] load_tag,
    output logic [31:0] load_data
);

    ls_sub_unit_if ls_if ();
    avalon_if av_bus ();

    logic [31:0] bus_data;       // captured readdata
    ls_load_info_t load_info;

    // ==============================
    // bus pins
    // ==============================
    assign avm_addr = av_bus.addr;
    assign avm_byteenable = av_bus.byteenable;
    assign avm_writedata = av_bus.writedata;
    assign avm_read = av_bus.read;
    assign avm_write = av_bus.write;
    assign av_bus.readdata = avm_readdata;
    assign av_bus.waitrequest = avm_waitrequest;

    // ==============================
    // stages
    // ==============================
    ls_decode i_ls_decode (
        .clk(clk), .rst(rst),
        .issue_valid(issue_valid), .issue_ready(issue_ready),
        .instr(instr),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .issue_tag(issue_tag),
        .ls(ls_if.issuer)
    );

    avalon_master i_avalon_master (
        .clk(clk), .rst(rst),
        .m_avalon(av_bus.master),
        .data_out(bus_data),
        .ls(ls_if.sub_unit),
        .load_info(load_info)
    );

    ls_load_align i_ls_load_align (
        .clk(clk), .rst(rst),
        .data_valid(ls_if.data_valid),
        .data_in(bus_data),
        .info(load_info),
        .load_valid(load_valid), .load_tag(load_tag), .load_data(load_data)
    );

endmodule

//--- testbench/lsu_avalon_sva.sv
`timescale 1ns/100ps

module lsu_avalon_sva (
    input logic clk,
    input logic rst,
    input logic [31:0] avm_addr,
    input logic [3:0] avm_byteenable,
    input logic [31:0] avm_writedata,
    input logic avm_read,
    input logic avm_write,
    input logic avm_waitrequest
);

    // one transfer kind at a time
    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(avm_read && avm_write))
        else $error("read and write high together");

    // stalled transfer keeps command and payload
    hold_under_wait: assert property (@(posedge clk) disable iff (rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_read) && $stable(avm_write) && $stable(avm_addr)
            && $stable(avm_byteenable) && $stable(avm_writedata))
        else $error("bus command changed under waitrequest");

    idle_in_reset: assert property (@(posedge clk) rst |=> !avm_read && !avm_write)
        else $error("bus active during reset");

endmodule

bind lsu_avalon_top lsu_avalon_sva i_lsu_avalon_sva (
    .clk(clk), .rst(rst),
    .avm_addr(avm_addr), .avm_byteenable(avm_byteenable),
    .avm_writedata(avm_writedata),
    .avm_read(avm_read), .avm_write(avm_write),
    .avm_waitrequest(avm_waitrequest)
);

//--- testbench/tb_lsu_avalon.sv
`timescale 1ns/100ps
`include "lsu_defines.svh"

module tb_lsu_avalon;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    logic issue_ready;
    logic [31:0] instr;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [`LSU_TAG_W-1:0] issue_tag;
    logic [31:0] avm_addr;
    logic [3:0] avm_byteenable;
    logic [31:0] avm_writedata;
    logic avm_read;
    logic avm_write;
    logic [31:0] avm_readdata;
    logic avm_waitrequest = 1'b1;   // stalled until the first reset edge
    logic load_valid;
    logic [`LSU_TAG_W-1:0] load_tag;
    logic [31:0] load_data;

    logic [31:0] mem [64];          // slave storage
    logic [31:0] shadow [64];       // program order copy
    logic [1:0] stall_cnt = 2'd0;   // wait cycles left on current transfer
    logic [31:0] exp_data_q [$];
    logic [`LSU_TAG_W-1:0] exp_tag_q [$];
    logic [`LSU_TAG_W-1:0] tag_cnt;

    lsu_avalon_top i_lsu_avalon_top (.*);

    always #50 clk = ~clk;

    // ==============================
    // helpers and reference
    // ==============================
    function automatic logic [31:0] fill_word(input logic [5:0] a);
        return {2'b10, a, ~a, a, ~a, a};   // unique per word index
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    function automatic void store_into_shadow(input logic [5:0] w, input logic [1:0] off,
                                              input logic [1:0] width, input logic [31:0] data);
        case (width)
            2'd0: shadow[w][{off, 3'b000} +: 8] = data[7:0];     // one lane
            2'd1: shadow[w][{off, 3'b000} +: 16] = data[15:0];   // two lanes
            default: shadow[w] = data;
        endcase
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] word, input logic [1:0] off,
                                                 input logic [1:0] width, input logic uns);
        logic [31:0] lane;
        logic [31:0] result;
        lane = word >> {off, 3'b000};   // addressed byte down to bit 0
        case (width)
            2'd0: result = uns ? {24'd0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            2'd1: result = uns ? {16'd0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
            default: result = word;
        endcase
        return result;
    endfunction

    // kind 0..7 is LB LH LW LBU LHU SB SH SW
    task automatic issue_random(input int unsigned kind);
        logic store;
        logic uns;
        logic [1:0] width;
        logic [1:0] off;
        logic [5:0] word_idx;
        logic [11:0] imm;
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0] f3;
        int waited;
        store = (kind >= 5);
        uns = (kind == 3 || kind == 4);
        width = (kind == 2 || kind == 7) ? 2'd2 :
                (kind == 1 || kind == 4 || kind == 6) ? 2'd1 : 2'd0;
        word_idx = 6'($urandom);
        off = (width == 2'd0) ? 2'($urandom) : (width == 2'd1) ? {1'($urandom), 1'b0} : 2'd0;
        imm = 12'($urandom);
        data = $urandom;
        addr = {24'd0, word_idx, off};   // aligned, inside the window
        f3 = {uns, width};
        @(posedge clk);
        issue_valid <= 1'b1;
        if (store)
            instr <= {imm[11:5], 5'($urandom), 5'($urandom), f3, imm[4:0], `LSU_OP_STORE};
        else
            instr <= {imm, 5'($urandom), f3, 5'($urandom), `LSU_OP_LOAD};
        rs1_value <= addr - {{20{imm[11]}}, imm};   // base plus offset lands on addr
        rs2_value <= data;
        issue_tag <= tag_cnt;
        waited = 0;
        @(negedge clk);
        while (!issue_ready) begin   // holder full, bus busy
            waited++;
            if (waited > 1000)
                fail_stop("timeout waiting for issue_ready");
            @(negedge clk);
        end
        // accepted at the coming edge
        if (store) begin
            store_into_shadow(word_idx, off, width, data);
        end else begin
            exp_data_q.push_back(expected_load(shadow[word_idx], off, width, uns));
            exp_tag_q.push_back(tag_cnt);
        end
        tag_cnt = tag_cnt + `LSU_TAG_W'(1);
    endtask

    // ==============================
    // avalon slave model
    // ==============================
    assign avm_readdata = mem[avm_addr[7:2]];   // valid in the completing cycle

    always @(posedge clk) begin : slave_model
        logic [1:0] next_stall;
        logic [31:0] merged;
        next_stall = stall_cnt;
        if (rst) begin
            for (int i = 0; i < 64; i++)
                mem[6'(i)] <= fill_word(6'(i));
            next_stall = 2'($urandom);
        end else if (avm_read || avm_write) begin
            if (stall_cnt != 2'd0) begin
                next_stall = stall_cnt - 2'd1;
            end else begin
                merged = mem[avm_addr[7:2]];   // completing cycle
                for (int b = 0; b < 4; b++)
                    if (avm_byteenable[2'(b)])
                        merged[{2'(b), 3'b000} +: 8] = avm_writedata[{2'(b), 3'b000} +: 8];
                if (avm_write)
                    mem[avm_addr[7:2]] <= merged;
                next_stall = 2'($urandom);   // stall for the next transfer
            end
        end
        stall_cnt <= next_stall;
        avm_waitrequest <= (next_stall != 2'd0);
    end

    // ==============================
    // compare
    // ==============================
    always @(negedge clk) begin : compare
        logic [31:0] exp_data;
        logic [`LSU_TAG_W-1:0] exp_tag;
        if (!rst && load_valid) begin
            if (exp_data_q.size() == 0) begin
                fail_stop("load result arrived with no load outstanding");
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_tag = exp_tag_q.pop_front();
                assert (load_tag == exp_tag)
                    else fail_stop($sformatf("[ERROR] load_tag expected %h got %h",
                                             exp_tag, load_tag));
                assert (load_data == exp_data)
                    else fail_stop($sformatf("[ERROR] load_data expected %h got %h",
                                             exp_data, load_data));
            end
        end
    end

    // ==============================
    // stimulus
    // ==============================
    initial begin : stimulus
        int unsigned kind;
        int waited;
        void'($urandom(93633));
        rst <= 1'b1;
        issue_valid <= 1'b0;
        instr <= '0;
        rs1_value <= '0;
        rs2_value <= '0;
        issue_tag <= '0;
        tag_cnt = '0;
        for (int i = 0; i < 64; i++)
            shadow[6'(i)] = fill_word(6'(i));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!avm_read && !avm_write && !load_valid && issue_ready)
            else fail_stop("bus or result active, or issue blocked, right after reset");
        for (int n = 0; n < 400; n++) begin
            kind = $urandom % 8;
            issue_random(kind);
            if ($urandom % 6 == 0) begin
                @(posedge clk);
                issue_valid <= 1'b0;   // idle gap
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (exp_data_q.size() != 0 || avm_read || avm_write) begin
            waited++;
            if (waited > 1000)
                fail_stop("timeout draining outstanding loads");
            @(negedge clk);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- build.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_ifs.sv
hw/ls_decode.sv
hw/avalon_master.sv
hw/ls_load_align.sv
hw/lsu_avalon_top.sv
testbench/lsu_avalon_sva.sv
testbench/tb_lsu_avalon.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_lsu_avalon -o tb_lsu_avalon
./obj_dir/tb_lsu_avalon > sim.log 2>&1 || true
cat sim.log
if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
